// File: rayCaster.f
rtl/rayTracePkg.sv
rtl/rcpIf.sv
rtl/reciprocal.sv
rtl/mapRom.sv
rtl/wallTracer.sv
rtl/rayCaster.sv
verif/rayCaster_sva.sv
verif/rayCasterTb.sv

// File: rtl/mapRom.sv
`timescale 1ns/10ps

module mapRom #(
  parameter int mapWidthBits  = 4,
  parameter int mapHeightBits = 4
) (
  input  logic [mapWidthBits-1:0]  i_col,
  input  logic [mapHeightBits-1:0] i_row,
  output logic                     o_wall
);

  logic colEdge;
  logic rowEdge;
  logic pillar;

  // The first and last column are solid so a ray can never leave the map
  assign colEdge = (i_col == '0) || (i_col == '1);

  // Same closure along the top and bottom rows
  assign rowEdge = (i_row == '0) || (i_row == '1);

  // Interior pillars sit on a 4 by 4 lattice
  // A cell is a pillar when both its column and row are 2 modulo 4
  assign pillar = (i_col[1:0] == 2'd2) && (i_row[1:0] == 2'd2);

  // Any of the three conditions makes the cell a wall
  assign o_wall = colEdge || rowEdge || pillar;

endmodule

// File: rtl/rayCaster.sv
`timescale 1ns/10ps

module rayCaster #(
  parameter int mapWidthBits  = 4,
  parameter int mapHeightBits = 4
) (
  input  logic              clk,
  input  logic              do_reset,
  input  logic              i_vsync,
  input  rayTracePkg::fixT  i_playerX,
  input  rayTracePkg::fixT  i_playerY,
  input  rayTracePkg::fixT  i_facingX,
  input  rayTracePkg::fixT  i_facingY,
  input  rayTracePkg::fixT  i_vplaneX,
  input  rayTracePkg::fixT  i_vplaneY,
  output logic              o_resultValid,
  input  logic              i_resultReady,
  output logic              o_side,
  output rayTracePkg::sizeT o_size
);

  logic [mapWidthBits-1:0]  mapCol;
  logic [mapHeightBits-1:0] mapRow;
  logic                     mapWall;

  // Channel to the one divider shared by all three reciprocals of a row
  rcpIf rcpBus ();

  reciprocal i_reciprocal (
    .clk      (clk),
    .do_reset (do_reset),
    .i_rcp    (rcpBus.server)
  );

  // Tile map answers within the same cycle
  mapRom #(
    .mapWidthBits  (mapWidthBits),
    .mapHeightBits (mapHeightBits)
  ) i_mapRom (
    .i_col  (mapCol),
    .i_row  (mapRow),
    .o_wall (mapWall)
  );

  wallTracer #(
    .mapWidthBits  (mapWidthBits),
    .mapHeightBits (mapHeightBits)
  ) i_wallTracer (
    .clk           (clk),
    .do_reset      (do_reset),
    .i_vsync       (i_vsync),
    .i_playerX     (i_playerX),
    .i_playerY     (i_playerY),
    .i_facingX     (i_facingX),
    .i_facingY     (i_facingY),
    .i_vplaneX     (i_vplaneX),
    .i_vplaneY     (i_vplaneY),
    .o_mapCol      (mapCol),
    .o_mapRow      (mapRow),
    .i_mapWall     (mapWall),
    .i_rcp         (rcpBus.requester),
    .o_resultValid (o_resultValid),
    .i_resultReady (i_resultReady),
    .o_side        (o_side),
    .o_size        (o_size)
  );

endmodule

// File: rtl/rayTracePkg.sv
package rayTracePkg;

  // Integer and fraction bit counts of the signed Q12.12 format
  localparam int qM = 12;
  localparam int qN = 12;

  // Signed Q12.12 value used for positions, vectors and step distances
  typedef logic signed [qM+qN-1:0] fixT;

  // Unsigned view of the same bits for the grid track distances
  // They can wrap past the signed range when a saturated step is added
  typedef logic [qM+qN-1:0] ufixT;

  // UQ7.9 wall distance taken from Q12.12 bits 6 down to -9
  typedef logic [15:0] vdistT;

  // Wall half-size in screen rows
  typedef logic [10:0] sizeT;

  // Source feeding the shared reciprocal unit
  typedef enum logic [1:0] {
    rcpRayDirX = 2'd0,
    rcpRayDirY = 2'd1,
    rcpVdist   = 2'd2
  } rcpSelT;

  // Per-row tracer states
  typedef enum logic [2:0] {
    sdxReq    = 3'd0,
    sdxWait   = 3'd1,
    sdyReq    = 3'd2,
    sdyWait   = 3'd3,
    tracePrep = 3'd4,
    traceStep = 3'd5,
    sizeReq   = 3'd6,
    traceDone = 3'd7
  } traceStateT;

  // The first row of a frame is deflected by this many camera planes
  localparam int rayRows = 272;

  // One quotient bit per divider iteration
  localparam int rcpIters = 24;

endpackage

// File: rtl/rcpIf.sv
`timescale 1ns/10ps

// Request and response channel between the tracer and the shared reciprocal
interface rcpIf;

  // Request side, which transfers when reqValid and reqReady are both high
  logic             reqValid;
  logic             reqReady;
  rayTracePkg::fixT operand;

  // Response side is a single-cycle pulse with no back-pressure
  logic             rspValid;
  rayTracePkg::fixT result;
  logic             sat;

  // The tracer issues operands and always takes the response pulse
  modport requester (
    output reqValid,
    output operand,
    input  reqReady,
    input  rspValid,
    input  result,
    input  sat
  );

  // The divider accepts operands only while idle
  modport server (
    input  reqValid,
    input  operand,
    output reqReady,
    output rspValid,
    output result,
    output sat
  );

endinterface

// File: rtl/reciprocal.sv
`timescale 1ns/10ps

module reciprocal (
  input  logic clk,
  input  logic do_reset,
  rcpIf.server i_rcp
);

  localparam int fixBits = rayTracePkg::qM + rayTracePkg::qN;
  localparam int cntBits = $clog2(rayTracePkg::rcpIters);
  localparam logic [cntBits-1:0] lastIter = cntBits'(rayTracePkg::rcpIters - 1);

  // Largest positive Q12.12 raw value, returned whenever the quotient overflows
  localparam rayTracePkg::fixT satValue = {1'b0, {(fixBits-1){1'b1}}};

  // Divisors of two or less give 2^24/d of at least 2^23, which does not fit
  // This also covers the divide by zero case
  localparam rayTracePkg::ufixT satLimit = rayTracePkg::ufixT'(2);

  logic                busy;
  logic [cntBits-1:0]  iterCnt;
  logic                rspValid;
  rayTracePkg::fixT    result;
  logic                satOut;

  rayTracePkg::ufixT   opAbs;
  rayTracePkg::ufixT   divisor;
  logic                satPend;
  logic [fixBits:0]    rem;
  rayTracePkg::ufixT   quot;

  logic [fixBits:0]    remShift;
  logic                takeBit;
  logic [fixBits:0]    remNext;
  rayTracePkg::ufixT   quotNext;

  // Magnitude of the operand, where -2^23 maps cleanly onto 2^23
  assign opAbs = i_rcp.operand[fixBits-1] ? rayTracePkg::ufixT'(-i_rcp.operand)
                                          : rayTracePkg::ufixT'(i_rcp.operand);

  // One restoring step brings down a zero dividend bit and tries the subtract
  assign remShift = {rem[fixBits-1:0], 1'b0};
  assign takeBit  = remShift >= {1'b0, divisor};
  assign remNext  = takeBit ? remShift - {1'b0, divisor} : remShift;
  assign quotNext = {quot[fixBits-2:0], takeBit};

  // The divider only takes new work while idle
  assign i_rcp.reqReady = ~busy;
  assign i_rcp.rspValid = rspValid;
  assign i_rcp.result   = result;
  assign i_rcp.sat      = satOut;

  // Busy runs from the request transfer through the response pulse
  always_ff @(posedge clk) begin
    if (do_reset) begin
      busy     <= 1'b0;
      iterCnt  <= '0;
      rspValid <= 1'b0;
    end else begin
      rspValid <= 1'b0;
      if (!busy) begin
        if (i_rcp.reqValid) begin
          busy    <= 1'b1;
          iterCnt <= '0;
        end
      end else if (rspValid) begin
        // Ready comes back on the cycle after the pulse
        busy <= 1'b0;
      end else if (iterCnt == lastIter) begin
        rspValid <= 1'b1;
      end else begin
        iterCnt <= iterCnt + 1'b1;
      end
    end
  end

  // Datapath for the shift and subtract loop
  always_ff @(posedge clk) begin
    if (!busy && i_rcp.reqValid) begin
      divisor <= opAbs;
      satPend <= opAbs <= satLimit;
      // The leading 1 of the 2^24 dividend is already brought down
      // Its quotient bit is 0 for every divisor that does not saturate
      rem     <= {{fixBits{1'b0}}, 1'b1};
      quot    <= '0;
    end else if (busy && !rspValid) begin
      rem  <= remNext;
      quot <= quotNext;
    end
    // The last iteration writes the final quotient straight into the result
    if (busy && !rspValid && iterCnt == lastIter) begin
      result <= satPend ? satValue : rayTracePkg::fixT'(quotNext);
      satOut <= satPend;
    end
  end

endmodule

// File: rtl/wallTracer.sv
`timescale 1ns/10ps

module wallTracer #(
  parameter int mapWidthBits  = 4,
  parameter int mapHeightBits = 4
) (
  input  logic                     clk,
  input  logic                     do_reset,
  input  logic                     i_vsync,
  input  rayTracePkg::fixT         i_playerX,
  input  rayTracePkg::fixT         i_playerY,
  input  rayTracePkg::fixT         i_facingX,
  input  rayTracePkg::fixT         i_facingY,
  input  rayTracePkg::fixT         i_vplaneX,
  input  rayTracePkg::fixT         i_vplaneY,
  output logic [mapWidthBits-1:0]  o_mapCol,
  output logic [mapHeightBits-1:0] o_mapRow,
  input  logic                     i_mapWall,
  rcpIf.requester                  i_rcp,
  output logic                     o_resultValid,
  input  logic                     i_resultReady,
  output logic                     o_side,
  output rayTracePkg::sizeT        o_size
);

  localparam int fixBits = rayTracePkg::qM + rayTracePkg::qN;

  // Q12.12 value of 1.0
  localparam rayTracePkg::fixT oneFix = rayTracePkg::fixT'(1 << rayTracePkg::qN);

  rayTracePkg::traceStateT state;
  rayTracePkg::rcpSelT     rcpSel;
  logic                    frameRestart;

  // Deflection accumulators hold a whole camera plane per row
  rayTracePkg::fixT        rayAddX;
  rayTracePkg::fixT        rayAddY;
  rayTracePkg::fixT        rayDirX;
  rayTracePkg::fixT        rayDirY;
  logic                    rayPosX;
  logic                    rayPosY;

  rayTracePkg::fixT        fracExtX;
  rayTracePkg::fixT        fracExtY;
  rayTracePkg::fixT        partialX;
  rayTracePkg::fixT        partialY;
  logic signed [2*fixBits-1:0] trackInitX;
  logic signed [2*fixBits-1:0] trackInitY;

  rayTracePkg::fixT        stepDistX;
  rayTracePkg::fixT        stepDistY;
  rayTracePkg::ufixT       trackDistX;
  rayTracePkg::ufixT       trackDistY;
  rayTracePkg::ufixT       wallDist;
  rayTracePkg::vdistT      vdist;
  logic                    needStepX;

  logic [mapWidthBits-1:0]  mapX;
  logic [mapHeightBits-1:0] mapY;
  logic                     side;

  logic                    reqValid;
  rayTracePkg::fixT        rcpOperand;
  logic                    rcpFire;

  // Vsync holds the tracer at the start of a frame just like reset
  assign frameRestart = do_reset || i_vsync;

  // The accumulators count whole planes, so scaling by 1/256 sets the field of view
  assign rayDirX = i_facingX + (rayAddX >>> 8);
  assign rayDirY = i_facingY + (rayAddY >>> 8);

  // Positive components walk toward higher cells
  assign rayPosX = rayDirX > 0;
  assign rayPosY = rayDirY > 0;

  // Fractional player position inside its cell
  assign fracExtX = {{rayTracePkg::qM{1'b0}}, i_playerX[rayTracePkg::qN-1:0]};
  assign fracExtY = {{rayTracePkg::qM{1'b0}}, i_playerY[rayTracePkg::qN-1:0]};

  // Part of a cell the ray crosses before it meets the first grid line
  // A zero fraction on a positive ray gives a full cell
  assign partialX = rayPosX ? oneFix - fracExtX : fracExtX;
  assign partialY = rayPosY ? oneFix - fracExtY : fracExtY;

  // The middle of the double-width product is the Q12.12 track start
  assign trackInitX = stepDistX * partialX;
  assign trackInitY = stepDistY * partialY;

  // Both trackers are unsigned so a wrapped saturated value still compares as far
  assign needStepX = trackDistX < trackDistY;

  // UQ7.9 slice of the hit distance
  assign vdist = wallDist[rayTracePkg::qN+6:rayTracePkg::qN-9];

  // The cell under test goes straight to the map and the wall flag returns in the same cycle
  assign o_mapCol = mapX;
  assign o_mapRow = mapY;

  // Pick what the shared divider works on
  always_comb begin
    case (rcpSel)
      rayTracePkg::rcpRayDirY: rcpOperand = rayDirY;
      rayTracePkg::rcpVdist:   rcpOperand = {5'b0, vdist, 3'b0};
      default:                 rcpOperand = rayDirX;
    endcase
  end

  assign rcpFire          = reqValid && i_rcp.reqReady;
  assign i_rcp.reqValid   = reqValid;
  assign i_rcp.operand    = rcpOperand;

  // Request states raise reqValid only after seeing reqReady, so a divider
  // still finishing an aborted operation is never offered a new one
  always_ff @(posedge clk) begin
    if (frameRestart) begin
      state         <= rayTracePkg::sdxReq;
      rcpSel        <= rayTracePkg::rcpRayDirX;
      reqValid      <= 1'b0;
      o_resultValid <= 1'b0;
      o_side        <= 1'b0;
      o_size        <= '0;
      side          <= 1'b0;
      // Top row starts at minus 272 camera planes
      rayAddX       <= rayTracePkg::fixT'(-(i_vplaneX * rayTracePkg::rayRows));
      rayAddY       <= rayTracePkg::fixT'(-(i_vplaneY * rayTracePkg::rayRows));
    end else begin
      case (state)
        // Step distance along X is the reciprocal of rayDirX
        rayTracePkg::sdxReq: begin
          if (rcpFire) begin
            reqValid <= 1'b0;
            state    <= rayTracePkg::sdxWait;
          end else if (i_rcp.reqReady) begin
            reqValid <= 1'b1;
          end
        end
        rayTracePkg::sdxWait: begin
          if (i_rcp.rspValid) begin
            stepDistX <= i_rcp.result;
            rcpSel    <= rayTracePkg::rcpRayDirY;
            state     <= rayTracePkg::sdyReq;
          end
        end

        // Step distance along Y follows the same round trip
        rayTracePkg::sdyReq: begin
          if (rcpFire) begin
            reqValid <= 1'b0;
            state    <= rayTracePkg::sdyWait;
          end else if (i_rcp.reqReady) begin
            reqValid <= 1'b1;
          end
        end
        rayTracePkg::sdyWait: begin
          if (i_rcp.rspValid) begin
            stepDistY <= i_rcp.result;
            state     <= rayTracePkg::tracePrep;
          end
        end

        // Start the walk in the player's own cell
        rayTracePkg::tracePrep: begin
          mapX       <= i_playerX[rayTracePkg::qN +: mapWidthBits];
          mapY       <= i_playerY[rayTracePkg::qN +: mapHeightBits];
          trackDistX <= trackInitX[rayTracePkg::qN +: fixBits];
          trackDistY <= trackInitY[rayTracePkg::qN +: fixBits];
          state      <= rayTracePkg::traceStep;
        end

        // One grid line per cycle until the map reports a wall
        rayTracePkg::traceStep: begin
          if (!i_mapWall) begin
            if (needStepX) begin
              mapX       <= rayPosX ? mapX + 1'b1 : mapX - 1'b1;
              trackDistX <= trackDistX + rayTracePkg::ufixT'(stepDistX);
              wallDist   <= trackDistX;
              side       <= 1'b0;
            end else begin
              mapY       <= rayPosY ? mapY + 1'b1 : mapY - 1'b1;
              trackDistY <= trackDistY + rayTracePkg::ufixT'(stepDistY);
              wallDist   <= trackDistY;
              side       <= 1'b1;
            end
          end else begin
            rcpSel <= rayTracePkg::rcpVdist;
            state  <= rayTracePkg::sizeReq;
          end
        end

        // Wall half-size is the reciprocal of the hit distance
        // This state covers both the request and the wait for its response
        rayTracePkg::sizeReq: begin
          if (i_rcp.rspValid) begin
            // Very near walls clamp to the full height
            o_size        <= i_rcp.sat ? '1
                                       : i_rcp.result[rayTracePkg::qN+2:rayTracePkg::qN-8];
            o_side        <= side;
            o_resultValid <= 1'b1;
            state         <= rayTracePkg::traceDone;
          end else if (rcpFire) begin
            reqValid <= 1'b0;
          end else if (i_rcp.reqReady) begin
            reqValid <= 1'b1;
          end
        end

        // Hold the result until it is taken and then move to the next row
        rayTracePkg::traceDone: begin
          if (i_resultReady) begin
            o_resultValid <= 1'b0;
            rayAddX       <= rayAddX + i_vplaneX;
            rayAddY       <= rayAddY + i_vplaneY;
            rcpSel        <= rayTracePkg::rcpRayDirX;
            state         <= rayTracePkg::sdxReq;
          end
        end
      endcase
    end
  end

endmodule

// File: runSim.sh
#!/bin/sh
# Build the ray caster testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rayCasterTb -f rayCaster.f -o rayCasterSim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/rayCasterSim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
  || { echo "Simulation finished without failures"; exit 0; }

// File: verif/rayCasterTb.sv
`timescale 1ns/10ps

module rayCasterTb;

  localparam int mapWidthBits  = 4;
  localparam int mapHeightBits = 4;
  localparam int numFrames     = 8;
  localparam int rowsPerFrame  = 16;
  // A row is three divider round trips plus a walk across the map, well under this
  localparam int rowCycles     = 200;
  localparam int cycleLimit    = numFrames * rowsPerFrame * rowCycles;
  // Frame that gets a vsync in the middle of a row
  localparam int abortFrame    = 3;
  localparam longint fixMask     = 64'hFF_FFFF;
  localparam longint satMax      = 64'h7F_FFFF;
  localparam longint rcpDividend = 1 << 24;
  localparam longint oneFix      = 1 << rayTracePkg::qN;

  logic              clk;
  logic              do_reset;
  logic              i_vsync;
  rayTracePkg::fixT  i_playerX;
  rayTracePkg::fixT  i_playerY;
  rayTracePkg::fixT  i_facingX;
  rayTracePkg::fixT  i_facingY;
  rayTracePkg::fixT  i_vplaneX;
  rayTracePkg::fixT  i_vplaneY;
  logic              o_resultValid;
  logic              i_resultReady;
  logic              o_side;
  rayTracePkg::sizeT o_size;

  int seed;
  int cycleCnt;
  int sideErrors;
  int sizeErrors;
  int validErrors;
  int frameIdx;
  int rowIdx;

  // Frame stimulus kept as plain integers so the model never reads the DUT
  longint playerX;
  longint playerY;
  longint facingX;
  longint facingY;
  longint vplaneX;
  longint vplaneY;
  // Model copy of the deflection accumulators
  longint mdlAddX;
  longint mdlAddY;

  rayCaster #(
    .mapWidthBits  (mapWidthBits),
    .mapHeightBits (mapHeightBits)
  ) i_rayCaster (
    .clk           (clk),
    .do_reset      (do_reset),
    .i_vsync       (i_vsync),
    .i_playerX     (i_playerX),
    .i_playerY     (i_playerY),
    .i_facingX     (i_facingX),
    .i_facingY     (i_facingY),
    .i_vplaneX     (i_vplaneX),
    .i_vplaneY     (i_vplaneY),
    .o_resultValid (o_resultValid),
    .i_resultReady (i_resultReady),
    .o_side        (o_side),
    .o_size        (o_size)
  );

  always #5 clk = ~clk;

  // Hard stop in case the tracer never hands a result over
  always @(posedge clk) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int randRange(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // Wraps a value into the signed 24-bit Q12.12 range
  function automatic longint toFix(input longint v);
    longint w;
    w = v & fixMask;
    if (w > satMax) w = w - (fixMask + 1);
    return w;
  endfunction

  // Closed border plus pillars on the 4 by 4 lattice
  function automatic bit isWall(input int col, input int row);
    int colMax;
    int rowMax;
    colMax = (1 << mapWidthBits) - 1;
    rowMax = (1 << mapHeightBits) - 1;
    return (col == 0) || (col == colMax) || (row == 0) || (row == rowMax) ||
           ((col % 4 == 2) && (row % 4 == 2));
  endfunction

  // Saturates for a zero operand or a quotient above the largest positive value
  function automatic bit recipSat(input longint op);
    longint mag;
    mag = (op < 0) ? -op : op;
    if (mag == 0) return 1'b1;
    return (rcpDividend / mag) > satMax;
  endfunction

  function automatic longint recipValue(input longint op);
    longint mag;
    mag = (op < 0) ? -op : op;
    if (recipSat(op)) return satMax;
    return rcpDividend / mag;
  endfunction

  task automatic checkSide(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      sideErrors++;
      $display("FAIL at %0t: side for %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic checkSize(input rayTracePkg::sizeT got, input rayTracePkg::sizeT exp,
                           input string what);
    if (got !== exp) begin
      sizeErrors++;
      $display("FAIL at %0t: size for %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkValid(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      validErrors++;
      $display("FAIL at %0t: result valid during %s is %0b, expected %0b",
               $time, what, got, exp);
    end
  endtask

  // Traces one row from the current deflection
  task automatic modelRow(output logic expSide, output rayTracePkg::sizeT expSize);
    longint dirX;
    longint dirY;
    longint stepX;
    longint stepY;
    longint trackX;
    longint trackY;
    longint partX;
    longint partY;
    longint wallD;
    longint sizeOp;
    int     mapX;
    int     mapY;
    int     guard;
    logic   side;
    // The accumulator holds whole planes and the field of view scales it by 1/256
    dirX  = toFix(facingX + (mdlAddX >>> 8));
    dirY  = toFix(facingY + (mdlAddY >>> 8));
    stepX = recipValue(dirX);
    stepY = recipValue(dirY);
    // Distance to the first grid line depends on which way the ray points
    partX = (dirX > 0) ? oneFix - (playerX & (oneFix - 1)) : (playerX & (oneFix - 1));
    partY = (dirY > 0) ? oneFix - (playerY & (oneFix - 1)) : (playerY & (oneFix - 1));
    trackX = ((stepX * partX) >> rayTracePkg::qN) & fixMask;
    trackY = ((stepY * partY) >> rayTracePkg::qN) & fixMask;
    mapX  = int'((playerX >> rayTracePkg::qN) & ((1 << mapWidthBits) - 1));
    mapY  = int'((playerY >> rayTracePkg::qN) & ((1 << mapHeightBits) - 1));
    wallD = 0;
    side  = 1'b0;
    guard = 0;
    while (!isWall(mapX, mapY) && guard < 64) begin
      // Ties go to the Y axis
      if (trackX < trackY) begin
        wallD  = trackX;
        trackX = (trackX + stepX) & fixMask;
        mapX   = ((dirX > 0) ? mapX + 1 : mapX - 1) & ((1 << mapWidthBits) - 1);
        side   = 1'b0;
      end else begin
        wallD  = trackY;
        trackY = (trackY + stepY) & fixMask;
        mapY   = ((dirY > 0) ? mapY + 1 : mapY - 1) & ((1 << mapHeightBits) - 1);
        side   = 1'b1;
      end
      guard++;
    end
    // The hit distance keeps bits 6 down to -9 and goes back into Q12.12
    sizeOp  = ((wallD >> 3) & 64'hFFFF) << 3;
    expSize = recipSat(sizeOp) ? '1 : rayTracePkg::sizeT'((recipValue(sizeOp) >> 4) & 64'h7FF);
    expSide = side;
  endtask

  // Player in an open cell, vectors anywhere within plus or minus 1.0
  task automatic randomFrame;
    int col;
    int row;
    col = 1 + randRange((1 << mapWidthBits) - 2);
    row = 1 + randRange((1 << mapHeightBits) - 2);
    while ((col % 4 == 2) && (row % 4 == 2)) begin
      col = 1 + randRange((1 << mapWidthBits) - 2);
      row = 1 + randRange((1 << mapHeightBits) - 2);
    end
    playerX = (longint'(col) << rayTracePkg::qN) | randRange(4096);
    playerY = (longint'(row) << rayTracePkg::qN) | randRange(4096);
    facingX = randRange(8193) - 4096;
    facingY = randRange(8193) - 4096;
    vplaneX = randRange(8193) - 4096;
    vplaneY = randRange(8193) - 4096;
  endtask

  // A hair away from the west wall, looking straight at it, so the size saturates
  task automatic directedFrame;
    playerX = (longint'(1) << rayTracePkg::qN) + 1;
    playerY = (longint'(5) << rayTracePkg::qN) + 2048;
    facingX = -4096;
    facingY = 0;
    vplaneX = 0;
    vplaneY = 0;
  endtask

  task automatic applyFrame;
    i_playerX     = rayTracePkg::fixT'(playerX);
    i_playerY     = rayTracePkg::fixT'(playerY);
    i_facingX     = rayTracePkg::fixT'(facingX);
    i_facingY     = rayTracePkg::fixT'(facingY);
    i_vplaneX     = rayTracePkg::fixT'(vplaneX);
    i_vplaneY     = rayTracePkg::fixT'(vplaneY);
    i_vsync       = 1'b1;
    i_resultReady = 1'b0;
    // First row sits 272 planes back
    mdlAddX = toFix(-(vplaneX * rayTracePkg::rayRows));
    mdlAddY = toFix(-(vplaneY * rayTracePkg::rayRows));
    repeat (3) begin
      @(posedge clk);
      #1;
      checkValid(o_resultValid, 1'b0, "vsync");
      checkSide(o_side, 1'b0, "vsync");
      checkSize(o_size, '0, "vsync");
    end
    i_vsync = 1'b0;
  endtask

  // Waits for one result and hands it over, optionally stalling it first
  task automatic takeRow(input int holdCycles);
    logic              expSide;
    rayTracePkg::sizeT expSize;
    bit                taken;
    int                holdLeft;
    string             tag;
    modelRow(expSide, expSize);
    tag      = $sformatf("frame %0d row %0d", frameIdx, rowIdx);
    holdLeft = holdCycles;
    taken    = 1'b0;
    while (!taken) begin
      @(posedge clk);
      #1;
      if (o_resultValid) begin
        // Every stalled cycle must still show the same result
        checkSide(o_side, expSide, tag);
        checkSize(o_size, expSize, tag);
        if (holdLeft > 0) begin
          i_resultReady = 1'b0;
          holdLeft--;
        end else begin
          i_resultReady = randRange(10) < 7;
        end
        taken = i_resultReady;
      end else begin
        i_resultReady = randRange(10) < 7;
      end
    end
    mdlAddX = toFix(mdlAddX + vplaneX);
    mdlAddY = toFix(mdlAddY + vplaneY);
  endtask

  task automatic runRows(input int count);
    for (rowIdx = 0; rowIdx < count; rowIdx++) begin
      takeRow(((frameIdx % 2 == 1) && (rowIdx == 2)) ? 12 : 0);
    end
  endtask

  // Leaves the next row with its step distance request still in the divider
  task automatic pauseMidRow;
    @(posedge clk);
    #1;
    i_resultReady = 1'b0;
    repeat (20) begin
      @(posedge clk);
      #1;
      checkValid(o_resultValid, 1'b0, "aborted row");
    end
  endtask

  initial begin
    seed          = 42;
    cycleCnt      = 0;
    sideErrors    = 0;
    sizeErrors    = 0;
    validErrors   = 0;
    clk           = 1'b0;
    do_reset      = 1'b1;
    i_vsync       = 1'b0;
    i_playerX     = '0;
    i_playerY     = '0;
    i_facingX     = '0;
    i_facingY     = '0;
    i_vplaneX     = '0;
    i_vplaneY     = '0;
    i_resultReady = 1'b0;
    repeat (10) begin
      @(posedge clk);
      #1;
      checkValid(o_resultValid, 1'b0, "reset");
      checkSide(o_side, 1'b0, "reset");
      checkSize(o_size, '0, "reset");
    end
    do_reset = 1'b0;
    for (frameIdx = 0; frameIdx < numFrames; frameIdx++) begin
      if (frameIdx == 0) directedFrame();
      else randomFrame();
      applyFrame();
      if (frameIdx == abortFrame) begin
        runRows(6);
        pauseMidRow();
        randomFrame();
        applyFrame();
      end
      runRows(rowsPerFrame);
    end
    $display("side errors %0d, size errors %0d, valid errors %0d",
             sideErrors, sizeErrors, validErrors);
    if (sideErrors + sizeErrors + validErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verif/rayCaster_sva.sv
`timescale 1ns/10ps

module rayCasterSva (
  input logic              clk,
  input logic              do_reset,
  input logic              i_vsync,
  input logic              i_resultValid,
  input logic              i_resultReady,
  input logic              i_side,
  input rayTracePkg::sizeT i_size,
  input logic              i_reqValid,
  input logic              i_reqReady
);

  // A stalled result keeps its value until it is taken or a frame restarts
  holdResult: assert property (@(posedge clk) disable iff (do_reset || i_vsync)
    (i_resultValid && !i_resultReady) |=> (i_resultValid && $stable(i_side) && $stable(i_size)))
    else $error("result changed while stalled");

  // A new request only starts once the divider shows it is idle
  noReqWhileBusy: assert property (@(posedge clk) disable iff (do_reset)
    $rose(i_reqValid) |-> i_reqReady)
    else $error("request raised while the divider was busy");

  resetClearsValid: assert property (@(posedge clk) do_reset |=> !i_resultValid)
    else $error("result valid high after reset");

endmodule

bind wallTracer rayCasterSva i_rayCasterSva (
  .clk           (clk),
  .do_reset      (do_reset),
  .i_vsync       (i_vsync),
  .i_resultValid (o_resultValid),
  .i_resultReady (i_resultReady),
  .i_side        (o_side),
  .i_size        (o_size),
  .i_reqValid    (reqValid),
  .i_reqReady    (i_rcp.reqReady)
);
